// ==== src/stripe_pkg.sv ====
package stripe_pkg;

  // ------------------------------
  // geometry of the striped store
  // ------------------------------

  // number of banks, must stay a power of two so the bank index can wrap freely
  localparam int num_banks = 4;
  localparam int bank_idx_w = 2;

  // flat byte address seen by the manager, and the byte address inside one bank
  localparam int addr_w = 12;
  localparam int bank_addr_w = 10;

  localparam int data_w = 32;
  localparam int strb_w = 4;
  localparam int id_w = 4;
  localparam int words_per_bank = 256;

  // one flat byte address, read either whole or split into its stripe fields
  // consecutive words walk through the banks before the word index moves on
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [7:0]            word_idx;
      logic [bank_idx_w-1:0] bank_idx;
      logic [1:0]            byte_off;
    } fields;
  } stripe_addr_u;

  // write address from the manager
  typedef struct packed {
    logic [id_w-1:0] id;
    stripe_addr_u    addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
  } aw_req_t;

  // shortened write address for one bank, addr is the byte address in that bank
  typedef struct packed {
    logic [id_w-1:0]        id;
    logic [bank_addr_w-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } bank_aw_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_beat_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
  } b_resp_t;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam logic [1:0] burst_incr = 2'b01;

endpackage

// ==== src/stripe_wr.sv ====
module stripe_wr (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             aw_valid,
  input  stripe_pkg::aw_req_t                              aw,
  output logic                                             aw_ready,
  input  logic                                             w_valid,
  input  stripe_pkg::w_beat_t                              w,
  output logic                                             w_ready,
  output logic                                             b_valid,
  output stripe_pkg::b_resp_t                              b,
  input  logic                                             b_ready,
  output logic [stripe_pkg::num_banks-1:0]                 bank_aw_valid,
  output stripe_pkg::bank_aw_t [stripe_pkg::num_banks-1:0] bank_aw,
  input  logic [stripe_pkg::num_banks-1:0]                 bank_aw_ready,
  output logic [stripe_pkg::num_banks-1:0]                 bank_w_valid,
  output stripe_pkg::w_beat_t [stripe_pkg::num_banks-1:0]  bank_w,
  input  logic [stripe_pkg::num_banks-1:0]                 bank_w_ready,
  input  logic [stripe_pkg::num_banks-1:0]                 bank_b_valid,
  input  stripe_pkg::b_resp_t [stripe_pkg::num_banks-1:0]  bank_b,
  output logic [stripe_pkg::num_banks-1:0]                 bank_b_ready
);
  import stripe_pkg::*;

  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic [num_banks-1:0]  aw_done;
  logic [num_banks-1:0]  b_done;
  logic [num_banks-1:0]  b_done_next;
  logic [bank_idx_w-1:0] idx;
  logic [bank_idx_w-1:0] last_idx;
  logic [7:0]            stripes_todo;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs = w_valid && w_ready;
  assign b_hs = b_valid && b_ready;

  // ------------------------------
  // address split
  // ------------------------------

  // only one burst is in flight, so the port closes on acceptance
  // and opens again once the merged response has been taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready <= 1'b1;
    end else if (aw_hs) begin
      aw_ready <= 1'b0;
    end else if (b_hs) begin
      aw_ready <= 1'b1;
    end
  end

  // every bank gets the burst at once, each valid drops on its own handshake
  // aw_done remembers which banks have taken their address for this burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_aw_valid <= '0;
      aw_done <= '0;
    end else begin
      bank_aw_valid <= aw_hs ? '1 : (bank_aw_valid & ~bank_aw_ready);
      aw_done <= b_hs ? '0 : (aw_done | (bank_aw_valid & bank_aw_ready));
    end
  end

  // a bank below the start bank only sees its first beat in the next stripe,
  // so its word index starts one higher
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      for (int i = 0; i < num_banks; i++) begin
        bank_aw[i] <= '{
          id: aw.id,
          addr: {aw.addr.fields.word_idx + 8'(i < int'(aw.addr.fields.bank_idx)),
                 aw.addr.fields.byte_off},
          len: aw.len >> bank_idx_w,
          size: aw.size,
          burst: aw.burst
        };
      end
    end
  end

  // ------------------------------
  // beat routing
  // ------------------------------

  // idx walks the banks one beat at a time and wraps by itself
  // a stripe ends on the beat sent to the bank just before the start bank
  // stripes_todo hits zero during the final stripe, which flags last on every bank
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx <= '0;
      last_idx <= '0;
      stripes_todo <= '0;
    end else if (aw_hs) begin
      idx <= aw.addr.fields.bank_idx;
      last_idx <= aw.addr.fields.bank_idx - 1'b1;
      stripes_todo <= aw.len >> bank_idx_w;
    end else if (w_hs) begin
      idx <= idx + 1'b1;
      if (idx == last_idx) begin
        stripes_todo <= stripes_todo - 1'b1;
      end
    end
  end

  // the manager may only push a beat once the active bank owns its address
  assign w_ready = bank_w_ready[idx] && aw_done[idx];

  // an accepted beat shows up on its bank one cycle later
  // it stays there until that bank takes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_w_valid <= '0;
    end else begin
      bank_w_valid <= bank_w_valid & ~bank_w_ready;
      if (w_hs) begin
        bank_w_valid[idx] <= 1'b1;
      end
    end
  end

  // the manager's own last is ignored, each bank needs the last of its stripe
  always_ff @(posedge clk) begin
    if (w_hs) begin
      bank_w[idx] <= '{data: w.data, strb: w.strb, last: stripes_todo == '0};
    end
  end

  // ------------------------------
  // response merge
  // ------------------------------

  // bank responses are always taken at once and remembered in b_done
  assign bank_b_ready = '1;

  always_comb begin
    b_done_next = b_done | (bank_b_valid & bank_b_ready);
    if (b_hs) begin
      b_done_next = '0;
    end
  end

  // the merged response rises once the last bank has answered and holds
  // while b_ready is low, since b_done only clears on the handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done <= '0;
      b_valid <= 1'b0;
    end else begin
      b_done <= b_done_next;
      b_valid <= &b_done_next;
    end
  end

  // all banks saw the same burst, so bank 0 speaks for the whole set
  always_ff @(posedge clk) begin
    if (bank_b_valid[0] && bank_b_ready[0]) begin
      b <= bank_b[0];
    end
  end

endmodule

// ==== src/stripe_bank.sv ====
module stripe_bank (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          aw_valid,
  input  stripe_pkg::bank_aw_t          aw,
  output logic                          aw_ready,
  input  logic                          w_valid,
  input  stripe_pkg::w_beat_t           w,
  output logic                          w_ready,
  output logic                          b_valid,
  output stripe_pkg::b_resp_t           b,
  input  logic                          b_ready,
  input  logic                          rd_strobe,
  input  logic [7:0]                    rd_word_idx,
  output logic [stripe_pkg::data_w-1:0] rd_word
);
  import stripe_pkg::*;

  // number of byte offset bits below the word index
  localparam int off_w = $clog2(strb_w);

  logic [data_w-1:0]            mem [words_per_bank];
  logic [bank_addr_w-off_w-1:0] ptr;
  logic                         incr_burst;
  logic                         aw_hs;
  logic                         w_hs;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs = w_valid && w_ready;

  // ------------------------------
  // burst control
  // ------------------------------

  // three phases in turn: waiting for an address, taking beats, and
  // holding the response until the splitter takes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready <= 1'b1;
      w_ready <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_ready <= 1'b0;
        w_ready <= 1'b1;
      end
      // the response goes out the cycle after the final beat
      if (w_hs && w.last) begin
        w_ready <= 1'b0;
        b_valid <= 1'b1;
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
        aw_ready <= 1'b1;
      end
    end
  end

  // the response is known as soon as the burst type is seen
  // anything other than INCR is refused and leaves the store untouched
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      ptr <= aw.addr[bank_addr_w-1:off_w];
      incr_burst <= (aw.burst == burst_incr);
      b <= '{id: aw.id, resp: (aw.burst == burst_incr) ? resp_okay : resp_slverr};
    end else if (w_hs) begin
      ptr <= ptr + 1'b1;
    end
  end

  // ------------------------------
  // word store
  // ------------------------------

  // byte lanes are written only where strb is set
  // the read port returns the old word if both hit the same address
  always_ff @(posedge clk) begin
    if (w_hs && incr_burst) begin
      for (int i = 0; i < strb_w; i++) begin
        if (w.strb[i]) begin
          mem[ptr][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
    if (rd_strobe) begin
      rd_word <= mem[rd_word_idx];
    end
  end

endmodule

// ==== src/stripe_read_route.sv ====
module stripe_read_route (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                rd_strobe,
  input  stripe_pkg::stripe_addr_u                            rd_addr,
  output logic [stripe_pkg::num_banks-1:0]                    bank_rd_strobe,
  output logic [7:0]                                          bank_rd_word_idx,
  input  logic [stripe_pkg::num_banks-1:0][stripe_pkg::data_w-1:0] bank_rd_word,
  output logic                                                rd_valid,
  output logic [stripe_pkg::data_w-1:0]                       rd_data
);
  import stripe_pkg::*;

  // bank that will hold the result in the next cycle
  logic [bank_idx_w-1:0] sel;

  // every bank sees the word index but only the addressed one is strobed
  assign bank_rd_word_idx = rd_addr.fields.word_idx;

  always_comb begin
    bank_rd_strobe = '0;
    bank_rd_strobe[rd_addr.fields.bank_idx] = rd_strobe;
  end

  // the banks register their word, so the valid trails the strobe by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      sel <= rd_addr.fields.bank_idx;
    end
  end

  // pick the answering bank's registered word
  assign rd_data = bank_rd_word[sel];

endmodule

// ==== src/stripe_mem_top.sv ====
module stripe_mem_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          aw_valid,
  input  stripe_pkg::aw_req_t           aw,
  output logic                          aw_ready,
  input  logic                          w_valid,
  input  stripe_pkg::w_beat_t           w,
  output logic                          w_ready,
  output logic                          b_valid,
  output stripe_pkg::b_resp_t           b,
  input  logic                          b_ready,
  input  logic                          rd_strobe,
  input  stripe_pkg::stripe_addr_u      rd_addr,
  output logic                          rd_valid,
  output logic [stripe_pkg::data_w-1:0] rd_data
);
  import stripe_pkg::*;

  // splitter to bank channels
  logic [num_banks-1:0]             bank_aw_valid;
  bank_aw_t [num_banks-1:0]         bank_aw;
  logic [num_banks-1:0]             bank_aw_ready;
  logic [num_banks-1:0]             bank_w_valid;
  w_beat_t [num_banks-1:0]          bank_w;
  logic [num_banks-1:0]             bank_w_ready;
  logic [num_banks-1:0]             bank_b_valid;
  b_resp_t [num_banks-1:0]          bank_b;
  logic [num_banks-1:0]             bank_b_ready;

  // read route to bank signals
  logic [num_banks-1:0]             bank_rd_strobe;
  logic [7:0]                       bank_rd_word_idx;
  logic [num_banks-1:0][data_w-1:0] bank_rd_word;

  // port names match the wires above one for one
  stripe_wr i_stripe_wr (.*);

  stripe_read_route i_stripe_read_route (.*);

  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    stripe_bank i_stripe_bank (
      .clk        (clk),
      .rst_n      (rst_n),
      .aw_valid   (bank_aw_valid[i]),
      .aw         (bank_aw[i]),
      .aw_ready   (bank_aw_ready[i]),
      .w_valid    (bank_w_valid[i]),
      .w          (bank_w[i]),
      .w_ready    (bank_w_ready[i]),
      .b_valid    (bank_b_valid[i]),
      .b          (bank_b[i]),
      .b_ready    (bank_b_ready[i]),
      .rd_strobe  (bank_rd_strobe[i]),
      .rd_word_idx(bank_rd_word_idx),
      .rd_word    (bank_rd_word[i])
    );
  end

endmodule

// ==== test/stripe_asserts.sv ====
module stripe_stripe_asserts (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           aw_valid,
  input logic                           aw_ready,
  input stripe_pkg::aw_req_t            aw,
  input logic                           b_valid,
  input logic [stripe_pkg::num_banks-1:0] bank_w_valid
);
  timeunit 1ns;
  timeprecision 100ps;
  import stripe_pkg::*;

  // only one burst may be in flight, so no address while a response waits
  no_aw_during_b: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid |-> !(aw_valid && aw_ready))
    else $error("address accepted while a write response is pending");

  // beats go to one bank at a time
  one_bank_w: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(bank_w_valid))
    else $error("more than one bank write beat valid in a cycle");

  // only full width beats are striped
  full_size: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> aw.size == 3'($clog2(strb_w)))
    else $error("write address size is not the full data width");

  // every bank must get the same number of beats
  whole_stripes: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> aw.len[bank_idx_w-1:0] == {bank_idx_w{1'b1}})
    else $error("burst length is not a whole number of stripes");

endmodule

bind stripe_wr stripe_stripe_asserts i_stripe_stripe_asserts (.*);

// ==== include/stripe_tb_util.svh ====
`ifndef STRIPE_TB_UTIL_SVH
`define STRIPE_TB_UTIL_SVH

// start value for the pseudo random sequence
localparam logic [31:0] lcg_seed = 32'd90796;

// running totals kept by the compare tasks
int n_checks = 0;
int n_errors = 0;

// byte image of the whole memory, indexed by flat byte address
logic [7:0] ref_mem [stripe_pkg::num_banks * stripe_pkg::words_per_bank * stripe_pkg::strb_w];

// classic 32 bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// merge one beat into the model
// lanes with a low strobe keep their byte
task automatic ref_write(input stripe_pkg::stripe_addr_u addr,
                         input logic [stripe_pkg::data_w-1:0] data,
                         input logic [stripe_pkg::strb_w-1:0] strb);
  for (int i = 0; i < stripe_pkg::strb_w; i++) begin
    if (strb[i]) begin
      ref_mem[addr.flat + i] = data[8*i +: 8];
    end
  end
endtask

function automatic logic [stripe_pkg::data_w-1:0] ref_read(input stripe_pkg::stripe_addr_u addr);
  logic [stripe_pkg::data_w-1:0] word;
  for (int i = 0; i < stripe_pkg::strb_w; i++) begin
    word[8*i +: 8] = ref_mem[addr.flat + i];
  end
  return word;
endfunction

task automatic check_b(input stripe_pkg::b_resp_t got, input stripe_pkg::b_resp_t exp,
                       input string what);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("FAILED at %0d ns: %s, got id %0h resp %0h, expected id %0h resp %0h",
             $time, what, got.id, got.resp, exp.id, exp.resp);
  end
endtask

task automatic check_word(input logic [stripe_pkg::data_w-1:0] got,
                          input logic [stripe_pkg::data_w-1:0] exp, input string what);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("FAILED at %0d ns: %s, got %08h, expected %08h", $time, what, got, exp);
  end
endtask

`endif

// ==== test/stripe_tb.sv ====
module stripe_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import stripe_pkg::*;

  `include "stripe_tb_util.svh"

  // ------------------------------
  // run length and watchdog budget
  // ------------------------------

  localparam int clk_period_ns = 20;
  localparam int reset_cycles = 10;
  // beats over all bursts of the directed tests below
  localparam int total_beats = 4 + 32 + 8 + 8 + 16;
  // each beat may see gaps, a handshake and a two cycle readback
  localparam int beat_budget = 16;
  localparam int margin_cycles = 100;
  localparam int timeout_ns =
    clk_period_ns * (reset_cycles + total_beats * beat_budget + margin_cycles);

  logic              clk;
  logic              rst_n;
  logic              aw_valid;
  aw_req_t           aw;
  logic              aw_ready;
  logic              w_valid;
  w_beat_t           w;
  logic              w_ready;
  logic              b_valid;
  b_resp_t           b;
  logic              b_ready;
  logic              rd_strobe;
  stripe_addr_u      rd_addr;
  logic              rd_valid;
  logic [data_w-1:0] rd_data;

  logic [31:0] rnd_state = lcg_seed;
  int          errs_before;

  stripe_mem_top i_stripe_mem_top (.*);

  always #(clk_period_ns / 2) clk = ~clk;

  // a hung handshake would otherwise stall the run forever
  initial begin
    #(timeout_ns);
    $display("watchdog: no verdict after %0d ns, a DUT handshake never completed",
             timeout_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] next_rand();
    rnd_state = lcg_next(rnd_state);
    return rnd_state;
  endfunction

  task automatic expect_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  // start word picked so the whole burst stays inside the memory
  function automatic stripe_addr_u rand_addr(input int n);
    stripe_addr_u a;
    a.flat = addr_w'(((next_rand() >> 8) % (num_banks * words_per_bank - n + 1)) << 2);
    return a;
  endfunction

  function automatic aw_req_t make_req(input stripe_addr_u addr, input int n,
                                       input logic [1:0] burst);
    return '{id: id_w'(next_rand() >> 16), addr: addr, len: 8'(n - 1),
             size: 3'($clog2(strb_w)), burst: burst};
  endfunction

  task automatic fill_beats(input int n, input bit full,
                            output logic [data_w-1:0] data [$],
                            output logic [strb_w-1:0] strb [$]);
    data = {};
    strb = {};
    for (int k = 0; k < n; k++) begin
      data.push_back(next_rand());
      strb.push_back(full ? {strb_w{1'b1}} : strb_w'(next_rand() >> 16));
    end
  endtask

  // beat k of an INCR burst lands at the start address plus 4k
  task automatic apply_model(input stripe_addr_u start, input logic [data_w-1:0] data [$],
                             input logic [strb_w-1:0] strb [$]);
    stripe_addr_u a;
    for (int k = 0; k < data.size(); k++) begin
      a.flat = start.flat + addr_w'(4 * k);
      ref_write(a, data[k], strb[k]);
    end
  endtask

  // every task below starts and ends on a falling edge
  // ready signals come from registers, so they are stable there
  task automatic send_burst(input aw_req_t req, input logic [data_w-1:0] data [$],
                            input logic [strb_w-1:0] strb [$], input bit gaps);
    int gap;
    aw_valid = 1'b1;
    aw = req;
    while (!aw_ready) @(negedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    for (int k = 0; k < data.size(); k++) begin
      if (gaps) begin
        gap = int'((next_rand() >> 16) % 4);
        repeat (gap) @(negedge clk);
      end
      w_valid = 1'b1;
      w = '{data: data[k], strb: strb[k], last: k == data.size() - 1};
      while (!w_ready) @(negedge clk);
      @(negedge clk);
      w_valid = 1'b0;
    end
  endtask

  // b_ready stays low for hold cycles
  // the response must not move meanwhile
  task automatic take_resp(output b_resp_t got, input int hold);
    b_resp_t first;
    while (!b_valid) @(negedge clk);
    first = b;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      expect_bit(b_valid, 1'b1, "b_valid held under back-pressure");
      expect_bit(aw_ready, 1'b0, "aw_ready while response pending");
      check_b(b, first, "b held under back-pressure");
    end
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
    got = first;
  endtask

  task automatic write_and_check(input aw_req_t req, input logic [data_w-1:0] data [$],
                                 input logic [strb_w-1:0] strb [$], input bit gaps,
                                 input logic [1:0] exp_resp);
    b_resp_t got;
    send_burst(req, data, strb, gaps);
    take_resp(got, 0);
    check_b(got, b_resp_t'{id: req.id, resp: exp_resp}, "write response");
    if (exp_resp == resp_okay) begin
      apply_model(req.addr, data, strb);
    end
  endtask

  // rd_valid must be high for exactly the one cycle after the strobe
  task automatic read_back(input stripe_addr_u start, input int n);
    stripe_addr_u a;
    for (int k = 0; k < n; k++) begin
      a.flat = start.flat + addr_w'(4 * k);
      rd_addr = a;
      rd_strobe = 1'b1;
      @(negedge clk);
      rd_strobe = 1'b0;
      expect_bit(rd_valid, 1'b1, "rd_valid one cycle after strobe");
      check_word(rd_data, ref_read(a), $sformatf("word at %03h", a.flat));
      @(negedge clk);
      expect_bit(rd_valid, 1'b0, "rd_valid after its single cycle");
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (n_errors == errs) begin
      $display("test %-20s ok", name);
    end else begin
      $display("test %-20s %0d errors", name, n_errors - errs);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_reset_state();
    expect_bit(aw_ready, 1'b1, "aw_ready after reset");
    expect_bit(w_ready, 1'b0, "w_ready after reset");
    expect_bit(b_valid, 1'b0, "b_valid after reset");
    expect_bit(rd_valid, 1'b0, "rd_valid after reset");
  endtask

  // one beat per bank from a random start bank
  task automatic test_one_stripe();
    aw_req_t           req;
    logic [data_w-1:0] data [$];
    logic [strb_w-1:0] strb [$];
    req = make_req(rand_addr(num_banks), num_banks, burst_incr);
    fill_beats(num_banks, 1'b1, data, strb);
    write_and_check(req, data, strb, 1'b0, resp_okay);
    read_back(req.addr, num_banks);
  endtask

  // known contents first, so lanes with a low strobe have something to keep
  task automatic test_partial_strobes();
    aw_req_t           req;
    logic [data_w-1:0] data [$];
    logic [strb_w-1:0] strb [$];
    req = make_req(rand_addr(16), 16, burst_incr);
    fill_beats(16, 1'b1, data, strb);
    write_and_check(req, data, strb, 1'b0, resp_okay);
    req.id = id_w'(next_rand() >> 16);
    fill_beats(16, 1'b0, data, strb);
    write_and_check(req, data, strb, 1'b0, resp_okay);
    read_back(req.addr, 16);
  endtask

  // the next address is offered while the response is held back
  // and may only be taken after the handshake
  task automatic test_resp_backpressure();
    aw_req_t           req;
    aw_req_t           next_req;
    b_resp_t           got;
    logic [data_w-1:0] data [$];
    logic [strb_w-1:0] strb [$];
    req = make_req(rand_addr(num_banks), num_banks, burst_incr);
    fill_beats(num_banks, 1'b1, data, strb);
    send_burst(req, data, strb, 1'b0);
    apply_model(req.addr, data, strb);
    next_req = make_req(rand_addr(num_banks), num_banks, burst_incr);
    aw_valid = 1'b1;
    aw = next_req;
    take_resp(got, 5);
    check_b(got, b_resp_t'{id: req.id, resp: resp_okay}, "response after back-pressure");
    expect_bit(aw_ready, 1'b1, "aw_ready after response handshake");
    fill_beats(num_banks, 1'b1, data, strb);
    write_and_check(next_req, data, strb, 1'b0, resp_okay);
  endtask

  // a FIXED burst is refused by every bank and must leave the words alone
  task automatic test_fixed_burst();
    aw_req_t           req;
    logic [data_w-1:0] data [$];
    logic [strb_w-1:0] strb [$];
    req = make_req(rand_addr(num_banks), num_banks, burst_incr);
    fill_beats(num_banks, 1'b1, data, strb);
    write_and_check(req, data, strb, 1'b0, resp_okay);
    req.burst = 2'b00;
    fill_beats(num_banks, 1'b1, data, strb);
    write_and_check(req, data, strb, 1'b0, resp_slverr);
    read_back(req.addr, num_banks);
  endtask

  task automatic test_w_gaps();
    aw_req_t           req;
    logic [data_w-1:0] data [$];
    logic [strb_w-1:0] strb [$];
    req = make_req(rand_addr(16), 16, burst_incr);
    fill_beats(16, 1'b1, data, strb);
    write_and_check(req, data, strb, 1'b1, resp_okay);
    read_back(req.addr, 16);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    aw_valid = 1'b0;
    aw = '0;
    w_valid = 1'b0;
    w = '0;
    b_ready = 1'b0;
    rd_strobe = 1'b0;
    rd_addr = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    errs_before = n_errors;
    test_reset_state();
    report_test("reset state", errs_before);
    errs_before = n_errors;
    test_one_stripe();
    report_test("one stripe", errs_before);
    errs_before = n_errors;
    test_partial_strobes();
    report_test("partial strobes", errs_before);
    errs_before = n_errors;
    test_resp_backpressure();
    report_test("resp back-pressure", errs_before);
    errs_before = n_errors;
    test_fixed_burst();
    report_test("fixed burst", errs_before);
    errs_before = n_errors;
    test_w_gaps();
    report_test("w_valid gaps", errs_before);

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
src/stripe_pkg.sv
src/stripe_wr.sv
src/stripe_bank.sv
src/stripe_read_route.sv
src/stripe_mem_top.sv
test/stripe_asserts.sv
test/stripe_tb.sv
